// File: rtl/acc_pkg.sv
package acc_pkg;

   // codes 10 to 15 are undefined
   typedef enum logic [3:0] {
      OP_NOP = 4'h0,
      OP_LDI = 4'h1, // load immediate
      OP_ADD = 4'h2,
      OP_SUB = 4'h3,
      OP_NOT = 4'h4,
      OP_AND = 4'h5,
      OP_IOR = 4'h6,
      OP_XOR = 4'h7,
      OP_SHL = 4'h8, // zero fill
      OP_SHR = 4'h9  // zero fill
   } acc_op_t;

   // accumulator and immediate width
   typedef logic [7:0] acc_word_t;

   // opcode in bits 11:8, immediate in 7:0
   typedef struct packed {
      acc_op_t   op;
      acc_word_t imm;
   } acc_inst_t;

   typedef enum logic [1:0] {
      STATE_RESET = 2'h0,
      STATE_READY = 2'h1,
      STATE_ERROR = 2'h2 // sticky until reset
   } acc_state_t;

endpackage

// File: rtl/inst_queue.sv
`timescale 1ns/100ps

module inst_queue #(
   parameter int INST_DEPTH = 4
) (
   input  logic               clock,
   input  logic               reset,
   input  logic               push,
   input  acc_pkg::acc_inst_t push_data,
   input  logic               pop,
   output acc_pkg::acc_inst_t head,
   output logic               not_empty
);

   import acc_pkg::*;

   localparam int PTR_W = (INST_DEPTH > 1) ? $clog2(INST_DEPTH) : 1;
   localparam int CNT_W = $clog2(INST_DEPTH + 1);

   acc_inst_t        mem [INST_DEPTH];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [CNT_W-1:0] count;
   logic             pop_ok;

   // depth need not be a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(INST_DEPTH - 1)) begin
         next_ptr = '0;
      end else begin
         next_ptr = ptr + PTR_W'(1);
      end
   endfunction

   assign not_empty = (count != '0);
   assign pop_ok    = pop && not_empty; // never pop an empty queue
   assign head      = mem[rd_ptr];

   always_ff @(posedge clock) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop_ok) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({push, pop_ok})
            2'b10:   count <= count + CNT_W'(1);
            2'b01:   count <= count - CNT_W'(1);
            default: count <= count; // both or neither
         endcase
      end
   end

endmodule

// File: rtl/credit_counter.sv
`timescale 1ns/100ps

module credit_counter #(
   parameter int RESULT_CREDITS = 2
) (
   input  logic clock,
   input  logic reset,
   input  logic consume,
   input  logic credit_return,
   output logic has_credit
);

   localparam int CNT_W = $clog2(RESULT_CREDITS + 1);

   logic [CNT_W-1:0] count;

   assign has_credit = (count != '0);

   always_ff @(posedge clock) begin
      if (reset) begin
         count <= CNT_W'(RESULT_CREDITS); // full allowance
      end else begin
         case ({consume, credit_return})
            2'b10: begin
               count <= count - CNT_W'(1); // result sent
            end
            2'b01: begin
               count <= count + CNT_W'(1); // receiver freed a slot
            end
            default: begin
               count <= count;
            end
         endcase
      end
   end

endmodule

// File: rtl/acc_core.sv
`timescale 1ns/100ps

module acc_core (
   input  logic               clock,
   input  logic               reset,
   input  acc_pkg::acc_inst_t head,
   input  logic               not_empty,
   input  logic               has_credit,
   output logic               pop,
   output logic               consume,
   output logic               inst_credit,
   output logic               result_valid,
   output acc_pkg::acc_word_t result,
   output logic               error
);

   import acc_pkg::*;

   acc_state_t state;
   acc_word_t  accum;
   acc_word_t  acc_next;
   logic       op_known;

   assign result = accum; // qualified by result_valid
   assign error  = (state == STATE_ERROR);

   // next accumulator for the instruction at the queue head
   always_comb begin
      op_known = 1'b1;
      acc_next = accum;
      case (head.op)
         OP_NOP: acc_next = accum;
         OP_LDI: acc_next = head.imm;
         OP_ADD: acc_next = accum + head.imm; // wraps
         OP_SUB: acc_next = accum - head.imm;
         OP_NOT: acc_next = ~accum;
         OP_AND: acc_next = accum & head.imm;
         OP_IOR: acc_next = accum | head.imm;
         OP_XOR: acc_next = accum ^ head.imm;
         OP_SHL: acc_next = {accum[6:0], 1'b0};
         OP_SHR: acc_next = {1'b0, accum[7:1]};
         default: begin
            op_known = 1'b0;
            acc_next = '0;
         end
      endcase
   end

   // error state drains the queue without waiting for result credits
   always_comb begin
      case (state)
         STATE_READY: pop = not_empty && has_credit;
         STATE_ERROR: pop = not_empty;
         default:     pop = 1'b0;
      endcase
   end

   assign consume = (state == STATE_READY) && pop && op_known;

   always_ff @(posedge clock) begin
      if (reset) begin
         state        <= STATE_RESET;
         accum        <= '0;
         result_valid <= 1'b0;
         inst_credit  <= 1'b0;
      end else begin
         result_valid <= consume;
         inst_credit  <= pop; // one credit back per instruction taken
         case (state)
            STATE_RESET: begin
               state <= STATE_READY;
               accum <= '0;
            end
            STATE_READY: begin
               if (pop) begin
                  accum <= acc_next;
                  if (!op_known) begin
                     state <= STATE_ERROR;
                  end
               end
            end
            STATE_ERROR: begin
               state <= STATE_ERROR;
               accum <= '0;
            end
            default: begin
               state <= STATE_ERROR; // unused encoding
               accum <= '0;
            end
         endcase
      end
   end

endmodule

// File: rtl/acc_unit.sv
`timescale 1ns/100ps

module acc_unit #(
   parameter int INST_DEPTH     = 4,
   parameter int RESULT_CREDITS = 2
) (
   input  logic               clock,
   input  logic               reset,
   input  logic               inst_valid,
   input  acc_pkg::acc_inst_t inst,
   output logic               inst_credit,
   output logic               result_valid,
   output acc_pkg::acc_word_t result,
   input  logic               result_credit,
   output logic               error
);

   import acc_pkg::*;

   acc_inst_t head;
   logic      not_empty;
   logic      pop;
   logic      has_credit;
   logic      consume;

   inst_queue #(
      .INST_DEPTH (INST_DEPTH)
   ) queue0 (
      .clock     (clock),
      .reset     (reset),
      .push      (inst_valid),
      .push_data (inst),
      .pop       (pop),
      .head      (head),
      .not_empty (not_empty)
   );

   credit_counter #(
      .RESULT_CREDITS (RESULT_CREDITS)
   ) credits0 (
      .clock         (clock),
      .reset         (reset),
      .consume       (consume),
      .credit_return (result_credit),
      .has_credit    (has_credit)
   );

   acc_core core0 (
      .clock        (clock),
      .reset        (reset),
      .head         (head),
      .not_empty    (not_empty),
      .has_credit   (has_credit),
      .pop          (pop),
      .consume      (consume),
      .inst_credit  (inst_credit),
      .result_valid (result_valid),
      .result       (result),
      .error        (error)
   );

endmodule

// File: tests/acc_model.sv
`timescale 1ns/100ps

module acc_model;

   import acc_pkg::*;

   acc_word_t accum;
   logic      in_error;
   acc_word_t expected[$]; // results the DUT still owes in issue order

   function automatic void clear();
      accum    = '0;
      in_error = 1'b0;
      expected.delete();
   endfunction

   // takes each instruction in the order the sender issued it
   function automatic void send(input acc_inst_t i);
      logic [8:0] wide;
      if (!in_error) begin
         case (i.op)
            OP_NOP: accum = accum;
            OP_LDI: accum = i.imm;
            OP_ADD: begin
               wide  = {1'b0, accum} + {1'b0, i.imm};
               accum = wide[7:0]; // carry dropped
            end
            OP_SUB: begin
               wide  = {1'b0, accum} + {1'b0, ~i.imm} + 9'd1;
               accum = wide[7:0];
            end
            OP_NOT: accum = ~accum;
            OP_AND: accum = accum & i.imm;
            OP_IOR: accum = accum | i.imm;
            OP_XOR: accum = accum ^ i.imm;
            OP_SHL: accum = accum << 1;
            OP_SHR: accum = accum >> 1;
            default: begin
               in_error = 1'b1; // no result from here on
               accum    = '0;
            end
         endcase
         if (!in_error) begin
            expected.push_back(accum);
         end
      end
   endfunction

   function automatic int pending();
      return expected.size();
   endfunction

   function automatic acc_word_t pop_expected();
      return expected.pop_front();
   endfunction

   function automatic logic error_expected();
      return in_error;
   endfunction

endmodule

// File: tests/acc_unit_tb.sv
`timescale 1ns/100ps

module acc_unit_tb;

   import acc_pkg::*;

   localparam int          INST_DEPTH      = 4;
   localparam int          RESULT_CREDITS  = 2;
   localparam int          CLK_PERIOD      = 10;
   localparam logic [31:0] SEED            = 32'ha4f5c2e1;
   localparam int          ARITH_COUNT     = 400;
   localparam int          HOLD_COUNT      = 30;
   localparam int          HOLD_CYCLES     = 50;
   localparam int          ERROR_PRE       = 3;
   localparam int          ERROR_POST      = 10;
   localparam int          TOTAL_INSTS     = 2 * ARITH_COUNT + 1 + HOLD_COUNT
                                             + ERROR_PRE + 1 + ERROR_POST;
   localparam int          WATCHDOG_CYCLES = 20 * TOTAL_INSTS + 100;

   logic      clock;
   logic      reset;
   logic      inst_valid;
   acc_inst_t inst;
   logic      inst_credit;
   logic      result_valid;
   acc_word_t result;
   logic      result_credit;
   logic      error;

   string     test_name;
   int        cycle_count;
   int        sender_credits;
   int        random_left;
   int        test_sent;
   int        test_pulses;
   int        hold_results;
   logic      hold_credits;
   logic      error_seen;
   acc_word_t last_result;
   acc_inst_t directed[$];
   int        credit_due[$]; // cycles at which result credits go back

   acc_unit dut0 (
      .clock         (clock),
      .reset         (reset),
      .inst_valid    (inst_valid),
      .inst          (inst),
      .inst_credit   (inst_credit),
      .result_valid  (result_valid),
      .result        (result),
      .result_credit (result_credit),
      .error         (error)
   );

   acc_model model0 ();

   always #(CLK_PERIOD / 2) clock = ~clock;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   task automatic check_result(input string name, input acc_word_t expected,
                               input acc_word_t actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
         $display("*** TEST FAILED ***");
         $fatal(1);
      end
   endtask

   task automatic check_error(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s: expected error %b, actual %b", name, expected, actual);
         $display("*** TEST FAILED ***");
         $fatal(1);
      end
   endtask

   function automatic acc_inst_t random_defined();
      return acc_inst_t'({4'($urandom_range(9, 0)), 8'($urandom_range(255, 0))});
   endfunction

   function automatic acc_inst_t random_undefined();
      return acc_inst_t'({4'($urandom_range(15, 10)), 8'($urandom_range(255, 0))});
   endfunction

   task automatic observe();
      int        due;
      acc_word_t want;
      if (result_valid) begin
         if (model0.pending() == 0) begin
            abort_run($sformatf("%s: result %h came out with no result expected",
                                test_name, result));
         end
         want = model0.pop_expected();
         check_result(test_name, want, result);
         last_result = result;
         if (hold_credits) begin
            hold_results++;
         end
         due = cycle_count + int'($urandom_range(3, 0));
         if (credit_due.size() > 0 && due <= credit_due[$]) begin
            due = credit_due[$] + 1; // one return per cycle
         end
         credit_due.push_back(due);
      end
      if (inst_credit) begin
         sender_credits++;
         test_pulses++;
         if (sender_credits > INST_DEPTH) begin
            abort_run($sformatf("%s: DUT returned more instruction credits than it was sent",
                                test_name));
         end
      end
      if (error_seen && !error) begin
         check_error(test_name, 1'b1, error); // sticky
      end
      if (error && !model0.error_expected()) begin
         check_error(test_name, 1'b0, error);
      end
      error_seen = error_seen || error;
   endtask

   task automatic drive();
      acc_inst_t next;
      inst_valid    = 1'b0;
      inst          = '0;
      result_credit = 1'b0;
      if (!hold_credits && credit_due.size() > 0 && credit_due[0] <= cycle_count) begin
         result_credit = 1'b1;
         credit_due.delete(0);
      end
      if (sender_credits > 0 && (directed.size() > 0 || random_left > 0)
          && $urandom_range(3, 0) != 0) begin
         if (directed.size() > 0) begin
            next = directed.pop_front();
         end else begin
            next = random_defined();
            random_left--;
         end
         inst_valid = 1'b1;
         inst       = next;
         sender_credits--; // one credit per valid cycle
         test_sent++;
         model0.send(next);
      end
   endtask

   task automatic tick();
      @(negedge clock);
      cycle_count++;
      observe();
      drive();
   endtask

   task automatic wait_idle();
      while (random_left > 0 || directed.size() > 0 || sender_credits != INST_DEPTH
             || model0.pending() != 0 || credit_due.size() != 0) begin
         tick();
      end
      repeat (4) tick(); // catch stray outputs
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_sent   = 0;
      test_pulses = 0;
   endtask

   task automatic finish_test();
      wait_idle();
      if (test_pulses != test_sent) begin
         abort_run($sformatf("%s: %0d instructions sent but %0d instruction credits returned",
                             test_name, test_sent, test_pulses));
      end
   endtask

   task automatic apply_reset();
      @(negedge clock);
      reset         = 1'b1;
      inst_valid    = 1'b0;
      inst          = '0;
      result_credit = 1'b0;
      repeat (4) @(negedge clock);
      reset          = 1'b0;
      sender_credits = INST_DEPTH;
      random_left    = 0;
      hold_credits   = 1'b0;
      error_seen     = 1'b0;
      directed.delete();
      credit_due.delete();
      model0.clear();
   endtask

   task automatic run_arith(input string name);
      begin_test(name);
      random_left = ARITH_COUNT;
      finish_test();
      check_error(test_name, 1'b0, error);
   endtask

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles before the tests completed", WATCHDOG_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1);
   end

   initial begin
      void'($urandom(SEED));
      clock         = 1'b0;
      reset         = 1'b1;
      inst_valid    = 1'b0;
      inst          = '0;
      result_credit = 1'b0;
      cycle_count   = 0;
      hold_results  = 0;
      last_result   = '0;
      test_name     = "init";
      apply_reset();

      begin_test("reset_state");
      repeat (10) tick(); // nothing may come out while idle
      check_error(test_name, 1'b0, error);
      directed.push_back(acc_inst_t'({OP_NOT, 8'($urandom_range(255, 0))}));
      finish_test();
      check_result(test_name, 8'hff, last_result);

      run_arith("arith");

      begin_test("backpressure");
      hold_credits = 1'b1;
      hold_results = 0;
      random_left  = HOLD_COUNT;
      repeat (HOLD_CYCLES) tick();
      if (hold_results > RESULT_CREDITS) begin
         abort_run($sformatf("backpressure: %0d results came out with only %0d result credits",
                             hold_results, RESULT_CREDITS));
      end
      if (sender_credits != 0) begin
         abort_run("backpressure: sender never ran out of instruction credits during the hold");
      end
      hold_credits = 1'b0;
      finish_test();

      begin_test("error");
      repeat (ERROR_PRE) directed.push_back(random_defined());
      directed.push_back(random_undefined());
      random_left = ERROR_POST; // all of these must drain silently
      finish_test();
      check_error(test_name, 1'b1, error);

      apply_reset();
      test_name = "recovery";
      check_error(test_name, 1'b0, error);
      run_arith("recovery");

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// File: vlog.f
rtl/acc_pkg.sv
rtl/inst_queue.sv
rtl/credit_counter.sv
rtl/acc_core.sv
rtl/acc_unit.sv
tests/acc_model.sv
tests/acc_unit_tb.sv

// File: Makefile
TOP := acc_unit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)
	verilator --lint-only rtl/acc_pkg.sv rtl/inst_queue.sv rtl/credit_counter.sv \
		rtl/acc_core.sv rtl/acc_unit.sv --top-module acc_unit

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
